// ==== eth_pkg.sv ====
package eth_pkg;

	// Basic Ethernet header fields
	typedef logic [47:0] mac_addr_t;
	typedef logic [11:0] vlan_t;

	// I/G bit of the first octet on the wire, set for multicast and broadcast
	localparam int MCAST_BIT = 40;

	// Table index hash
	// XOR fold of the address into 16 bits, mixed with the VLAN ID
	// Callers keep only as many low bits as the table has rows
	function automatic logic [15:0] mac_vlan_hash(input mac_addr_t mac, input vlan_t vlan);
		logic [15:0] folded;
		folded = mac[47:32] ^ mac[31:16] ^ mac[15:0];
		return folded ^ {4'h0, vlan};
	endfunction

endpackage

// ==== mac_table_pkg.sv ====
package mac_table_pkg;

	import eth_pkg::*;

	// Entry width before the port field is added
	// mac + vlan + valid + gc_mark
	localparam int ENTRY_FIXED_BITS = $bits(mac_addr_t) + $bits(vlan_t) + 2;

	// Field positions, LSB first: mac, port, vlan, valid, gc_mark
	localparam int MAC_LSB  = 0;
	localparam int PORT_LSB = MAC_LSB + $bits(mac_addr_t);

	// Positions above the port field depend on its width
	function automatic int vlan_lsb(input int port_bits);
		return PORT_LSB + port_bits;
	endfunction

	function automatic int valid_bit(input int port_bits);
		return vlan_lsb(port_bits) + $bits(vlan_t);
	endfunction

	function automatic int mark_bit(input int port_bits);
		return valid_bit(port_bits) + 1;
	endfunction

	// Operation granted on the maintenance port this cycle
	typedef enum logic [2:0] {
		OP_NONE,
		OP_SRC_READ,
		OP_LEARN_WRITE,
		OP_GC_READ,
		OP_GC_WRITE
	} port_op_t;

	// Garbage collector states
	typedef enum logic [2:0] {
		GC_IDLE,
		GC_READ_WAIT,
		GC_CHECK,
		GC_WRITE_WAIT,
		GC_NEXT
	} gc_state_t;

endpackage

// ==== table_ram.sv ====
`timescale 1ns/1ps

module table_ram #(
	parameter int WIDTH = 64,
	parameter int DEPTH = 2048,
	localparam int ADDR_BITS = $clog2(DEPTH)
) (
	input  logic                 clk,

	// Port A, lookup side, read only
	input  logic                 a_en,
	input  logic [ADDR_BITS-1:0] a_addr,
	output logic [WIDTH-1:0]     a_rdata,

	// Port B, maintenance side
	input  logic                 b_en,
	input  logic                 b_we,
	input  logic [ADDR_BITS-1:0] b_addr,
	input  logic [WIDTH-1:0]     b_wdata,
	output logic [WIDTH-1:0]     b_rdata
);

	logic [WIDTH-1:0] mem [DEPTH];

	// Table comes up empty, every entry invalid
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (a_en) begin
			a_rdata <= mem[a_addr];
		end
	end

	// Write-first, so a write also shows up on b_rdata next cycle
	always_ff @(posedge clk) begin
		if (b_en) begin
			if (b_we) begin
				mem[b_addr] <= b_wdata;
				b_rdata     <= b_wdata;
			end else begin
				b_rdata <= mem[b_addr];
			end
		end
	end

endmodule

// ==== table_port_arbiter.sv ====
`timescale 1ns/1ps

module table_port_arbiter #(
	parameter int TABLE_ROWS = 2048,
	parameter int ASSOC_WAYS = 8,
	parameter int NUM_PORTS  = 50,
	localparam int PORT_BITS = $clog2(NUM_PORTS),
	localparam int ROW_BITS  = $clog2(TABLE_ROWS),
	localparam int WAY_BITS  = $clog2(ASSOC_WAYS),
	localparam int ENTRY_W   = mac_table_pkg::ENTRY_FIXED_BITS + PORT_BITS
) (
	input  logic                  clk,
	input  logic                  reset,

	// Source lookup, always wins
	input  logic                  lookup_en,
	input  logic [ROW_BITS-1:0]   src_index,

	// Learn writes
	input  logic                  learn_req,
	input  logic [ROW_BITS-1:0]   learn_row,
	input  logic [WAY_BITS-1:0]   learn_way,
	input  logic [ENTRY_W-1:0]    learn_data,
	output logic                  learn_grant,

	// Garbage collector reads and writes
	input  logic                  gc_rd_req,
	input  logic                  gc_wr_req,
	input  logic [ROW_BITS-1:0]   gc_row,
	input  logic [WAY_BITS-1:0]   gc_way,
	input  logic [ENTRY_W-1:0]    gc_data,
	output logic                  gc_rd_grant,
	output logic                  gc_wr_grant,

	// Port B of every way
	output logic                  b_en,
	output logic [ROW_BITS-1:0]   b_addr,
	output logic [ASSOC_WAYS-1:0] b_we,
	output logic [ENTRY_W-1:0]    b_wdata
);

	import mac_table_pkg::*;

	port_op_t op;

	//////////////////////////////
	// Fixed priority select

	// A request whose grant is showing this cycle was already served
	// Masking it keeps one access per request
	always_comb begin
		op = OP_NONE;
		if (lookup_en) begin
			op = OP_SRC_READ;
		end else if (learn_req && !learn_grant) begin
			op = OP_LEARN_WRITE;
		end else if (gc_rd_req && !gc_rd_grant) begin
			op = OP_GC_READ;
		end else if (gc_wr_req && !gc_wr_grant) begin
			op = OP_GC_WRITE;
		end
	end

	// Drive port B for the chosen op
	always_comb begin
		b_en    = (op != OP_NONE);
		b_addr  = '0;
		b_we    = '0;
		b_wdata = '0;
		case (op)
			OP_SRC_READ: begin
				b_addr = src_index;
			end
			OP_LEARN_WRITE: begin
				b_addr           = learn_row;
				b_we[learn_way]  = 1'b1;
				b_wdata          = learn_data;
			end
			OP_GC_READ: begin
				b_addr = gc_row;
			end
			OP_GC_WRITE: begin
				b_addr        = gc_row;
				b_we[gc_way]  = 1'b1;
				b_wdata       = gc_data;
			end
			default: begin
				b_addr = '0;
			end
		endcase
	end

	//////////////////////////////
	// Grants, one cycle after the access
	// Lines up with the RAM read data

	always_ff @(posedge clk) begin
		if (reset) begin
			learn_grant <= 1'b0;
			gc_rd_grant <= 1'b0;
			gc_wr_grant <= 1'b0;
		end else begin
			learn_grant <= (op == OP_LEARN_WRITE);
			gc_rd_grant <= (op == OP_GC_READ);
			gc_wr_grant <= (op == OP_GC_WRITE);
		end
	end

endmodule

// ==== dst_lookup.sv ====
`timescale 1ns/1ps

module dst_lookup #(
	parameter int ASSOC_WAYS = 8,
	parameter int NUM_PORTS  = 50,
	localparam int PORT_BITS = $clog2(NUM_PORTS),
	localparam int ENTRY_W   = mac_table_pkg::ENTRY_FIXED_BITS + PORT_BITS
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                lookup_en,
	input  eth_pkg::vlan_t                      lookup_vlan,
	input  eth_pkg::mac_addr_t                  lookup_dst_mac,
	input  logic [ASSOC_WAYS-1:0][ENTRY_W-1:0]  a_rdata,
	output logic                                lookup_hit,
	output logic [PORT_BITS-1:0]                lookup_dst_port
);

	import eth_pkg::*;
	import mac_table_pkg::*;

	localparam int VLAN_LSB  = vlan_lsb(PORT_BITS);
	localparam int VALID_BIT = valid_bit(PORT_BITS);

	// Request fields, one stage behind to meet the RAM data
	logic      en_d;
	vlan_t     vlan_d;
	mac_addr_t mac_d;

	logic                 hit_comb;
	logic [PORT_BITS-1:0] port_comb;

	always_ff @(posedge clk) begin
		if (reset) begin
			en_d <= 1'b0;
		end else begin
			en_d <= lookup_en;
		end
	end

	always_ff @(posedge clk) begin
		vlan_d <= lookup_vlan;
		mac_d  <= lookup_dst_mac;
	end

	// Compare every way
	// Should never see two hits, if it happens the highest way wins
	always_comb begin
		hit_comb  = 1'b0;
		port_comb = '0;
		for (int i = 0; i < ASSOC_WAYS; i++) begin
			if (a_rdata[i][VALID_BIT] &&
				(a_rdata[i][VLAN_LSB +: $bits(vlan_t)] == vlan_d) &&
				(a_rdata[i][MAC_LSB +: $bits(mac_addr_t)] == mac_d)) begin
				hit_comb  = 1'b1;
				port_comb = a_rdata[i][PORT_LSB +: PORT_BITS];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			lookup_hit <= 1'b0;
		end else begin
			lookup_hit <= en_d && hit_comb;
		end
	end

	// Port only means something alongside lookup_hit
	always_ff @(posedge clk) begin
		lookup_dst_port <= port_comb;
	end

endmodule

// ==== learn_check.sv ====
`timescale 1ns/1ps

module learn_check #(
	parameter int ASSOC_WAYS = 8,
	parameter int NUM_PORTS  = 50,
	localparam int PORT_BITS = $clog2(NUM_PORTS),
	localparam int WAY_BITS  = $clog2(ASSOC_WAYS),
	localparam int ENTRY_W   = mac_table_pkg::ENTRY_FIXED_BITS + PORT_BITS
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                lookup_en,
	input  eth_pkg::vlan_t                      lookup_vlan,
	input  eth_pkg::mac_addr_t                  lookup_src_mac,
	input  logic [PORT_BITS-1:0]                lookup_src_port,
	input  logic [ASSOC_WAYS-1:0][ENTRY_W-1:0]  b_rdata,
	output logic                                need_to_learn,
	output eth_pkg::mac_addr_t                  learn_mac,
	output eth_pkg::vlan_t                      learn_vlan,
	output logic [PORT_BITS-1:0]                learn_port,
	output logic [WAY_BITS-1:0]                 learn_way
);

	import eth_pkg::*;
	import mac_table_pkg::*;

	localparam int VLAN_LSB  = vlan_lsb(PORT_BITS);
	localparam int VALID_BIT = valid_bit(PORT_BITS);

	logic                 en_d;
	mac_addr_t            mac_d;
	vlan_t                vlan_d;
	logic [PORT_BITS-1:0] port_d;

	// Next way to learn into, plain round robin
	logic [WAY_BITS-1:0] rr_way;

	logic known;
	logic learn_now;

	always_ff @(posedge clk) begin
		mac_d  <= lookup_src_mac;
		vlan_d <= lookup_vlan;
		port_d <= lookup_src_port;
	end

	// Source already in some way of its row?
	always_comb begin
		known = 1'b0;
		for (int i = 0; i < ASSOC_WAYS; i++) begin
			if (b_rdata[i][VALID_BIT] &&
				(b_rdata[i][VLAN_LSB +: $bits(vlan_t)] == vlan_d) &&
				(b_rdata[i][MAC_LSB +: $bits(mac_addr_t)] == mac_d)) begin
				known = 1'b1;
			end
		end
	end

	// Group addresses never get learned
	assign learn_now = en_d && !known && !mac_d[MCAST_BIT];

	always_ff @(posedge clk) begin
		if (reset) begin
			en_d          <= 1'b0;
			need_to_learn <= 1'b0;
			rr_way        <= '0;
		end else begin
			en_d          <= lookup_en;
			need_to_learn <= learn_now;
			if (learn_now) begin
				if (rr_way == WAY_BITS'(ASSOC_WAYS - 1)) begin
					rr_way <= '0;
				end else begin
					rr_way <= rr_way + 1'b1;
				end
			end
		end
	end

	// Payload toward the pending set
	always_ff @(posedge clk) begin
		if (learn_now) begin
			learn_mac  <= mac_d;
			learn_vlan <= vlan_d;
			learn_port <= port_d;
			learn_way  <= rr_way;
		end
	end

endmodule

// ==== learn_queue.sv ====
`timescale 1ns/1ps

module learn_queue #(
	parameter int TABLE_ROWS   = 2048,
	parameter int ASSOC_WAYS   = 8,
	parameter int PENDING_SIZE = 8,
	parameter int NUM_PORTS    = 50,
	localparam int PORT_BITS   = $clog2(NUM_PORTS),
	localparam int ROW_BITS    = $clog2(TABLE_ROWS),
	localparam int WAY_BITS    = $clog2(ASSOC_WAYS),
	localparam int ENTRY_W     = mac_table_pkg::ENTRY_FIXED_BITS + PORT_BITS
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 need_to_learn,
	input  eth_pkg::mac_addr_t   learn_mac,
	input  eth_pkg::vlan_t       learn_vlan,
	input  logic [PORT_BITS-1:0] learn_port,
	input  logic [WAY_BITS-1:0]  learn_way,
	input  logic                 learn_grant,
	output logic                 learn_req,
	output logic [ROW_BITS-1:0]  learn_row,
	output logic [WAY_BITS-1:0]  learn_way_out,
	output logic [ENTRY_W-1:0]   learn_data
);

	import eth_pkg::*;

	localparam int PEND_BITS = $clog2(PENDING_SIZE);

	//////////////////////////////
	// Pending slots

	logic [PENDING_SIZE-1:0] slot_valid;
	mac_addr_t               slot_mac  [PENDING_SIZE];
	vlan_t                   slot_vlan [PENDING_SIZE];
	logic [PORT_BITS-1:0]    slot_port [PENDING_SIZE];
	logic [WAY_BITS-1:0]     slot_way  [PENDING_SIZE];

	// Slot currently offered to the arbiter
	logic [PEND_BITS-1:0] cur_slot;

	logic                 dup;
	logic                 free_found;
	logic [PEND_BITS-1:0] free_idx;
	logic                 pend_found;
	logic [PEND_BITS-1:0] pend_idx;
	logic [15:0]          pend_hash;

	// Duplicate check, then lowest free slot
	// Walk downward so the lowest index is the last one kept
	always_comb begin
		dup        = 1'b0;
		free_found = 1'b0;
		free_idx   = '0;
		pend_found = 1'b0;
		pend_idx   = '0;
		for (int i = PENDING_SIZE - 1; i >= 0; i--) begin
			if (slot_valid[i] && (slot_mac[i] == learn_mac) &&
				(slot_vlan[i] == learn_vlan) && (slot_port[i] == learn_port)) begin
				dup = 1'b1;
			end
			if (!slot_valid[i]) begin
				free_found = 1'b1;
				free_idx   = PEND_BITS'(i);
			end else begin
				pend_found = 1'b1;
				pend_idx   = PEND_BITS'(i);
			end
		end
	end

	// Row of the slot about to be offered
	assign pend_hash = mac_vlan_hash(slot_mac[pend_idx], slot_vlan[pend_idx]);

	// Full set drops the new address
	always_ff @(posedge clk) begin
		if (reset) begin
			slot_valid <= '0;
			learn_req  <= 1'b0;
		end else begin
			if (need_to_learn && !dup && free_found) begin
				slot_valid[free_idx] <= 1'b1;
			end
			// Write done, free the slot and drop the request
			if (learn_grant) begin
				slot_valid[cur_slot] <= 1'b0;
				learn_req            <= 1'b0;
			end else if (!learn_req && pend_found) begin
				learn_req <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (need_to_learn && !dup && free_found) begin
			slot_mac[free_idx]  <= learn_mac;
			slot_vlan[free_idx] <= learn_vlan;
			slot_port[free_idx] <= learn_port;
			slot_way[free_idx]  <= learn_way;
		end
	end

	// Request fields stay put until the grant
	// New entries go in marked so the next sweep keeps them
	always_ff @(posedge clk) begin
		if (!learn_req && !learn_grant && pend_found) begin
			cur_slot      <= pend_idx;
			learn_row     <= pend_hash[ROW_BITS-1:0];
			learn_way_out <= slot_way[pend_idx];
			learn_data    <= {1'b1, 1'b1, slot_vlan[pend_idx], slot_port[pend_idx],
				slot_mac[pend_idx]};
		end
	end

endmodule

// ==== gc_sweeper.sv ====
`timescale 1ns/1ps

module gc_sweeper #(
	parameter int TABLE_ROWS = 2048,
	parameter int ASSOC_WAYS = 8,
	parameter int NUM_PORTS  = 50,
	localparam int PORT_BITS = $clog2(NUM_PORTS),
	localparam int ROW_BITS  = $clog2(TABLE_ROWS),
	localparam int WAY_BITS  = $clog2(ASSOC_WAYS),
	localparam int ENTRY_W   = mac_table_pkg::ENTRY_FIXED_BITS + PORT_BITS
) (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                gc_en,
	output logic                                gc_done,
	input  logic [ASSOC_WAYS-1:0][ENTRY_W-1:0]  b_rdata,
	input  logic                                gc_rd_grant,
	input  logic                                gc_wr_grant,
	output logic                                gc_rd_req,
	output logic                                gc_wr_req,
	output logic [ROW_BITS-1:0]                 gc_row,
	output logic [WAY_BITS-1:0]                 gc_way,
	output logic [ENTRY_W-1:0]                  gc_data
);

	import mac_table_pkg::*;

	localparam int VALID_BIT = valid_bit(PORT_BITS);
	localparam int MARK_BIT  = mark_bit(PORT_BITS);

	gc_state_t state;

	// Entry under inspection
	logic [ENTRY_W-1:0] rd_entry;

	//////////////////////////////
	// Sweep FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state     <= GC_IDLE;
			gc_done   <= 1'b0;
			gc_rd_req <= 1'b0;
			gc_wr_req <= 1'b0;
			gc_row    <= '0;
			gc_way    <= '0;
		end else begin
			gc_done <= 1'b0;
			case (state)
				// Start requests are only taken here
				GC_IDLE: begin
					if (gc_en) begin
						gc_row    <= '0;
						gc_way    <= '0;
						gc_rd_req <= 1'b1;
						state     <= GC_READ_WAIT;
					end
				end
				// Grant comes with the read data
				GC_READ_WAIT: begin
					if (gc_rd_grant) begin
						gc_rd_req <= 1'b0;
						state     <= GC_CHECK;
					end
				end
				// Empty slots need no write
				GC_CHECK: begin
					if (rd_entry[VALID_BIT]) begin
						gc_wr_req <= 1'b1;
						state     <= GC_WRITE_WAIT;
					end else begin
						state <= GC_NEXT;
					end
				end
				GC_WRITE_WAIT: begin
					if (gc_wr_grant) begin
						gc_wr_req <= 1'b0;
						state     <= GC_NEXT;
					end
				end
				// Rows first, then ways
				GC_NEXT: begin
					if (gc_row == ROW_BITS'(TABLE_ROWS - 1)) begin
						if (gc_way == WAY_BITS'(ASSOC_WAYS - 1)) begin
							gc_done <= 1'b1;
							state   <= GC_IDLE;
						end else begin
							gc_way    <= gc_way + 1'b1;
							gc_row    <= '0;
							gc_rd_req <= 1'b1;
							state     <= GC_READ_WAIT;
						end
					end else begin
						gc_row    <= gc_row + 1'b1;
						gc_rd_req <= 1'b1;
						state     <= GC_READ_WAIT;
					end
				end
				default: begin
					state <= GC_IDLE;
				end
			endcase
		end
	end

	// Capture the entry while port B still holds it
	always_ff @(posedge clk) begin
		if ((state == GC_READ_WAIT) && gc_rd_grant) begin
			rd_entry <= b_rdata[gc_way];
		end
	end

	// Marked entries survive with the mark cleared
	// Unmarked ones are wiped
	always_ff @(posedge clk) begin
		if (state == GC_CHECK) begin
			if (rd_entry[MARK_BIT]) begin
				gc_data           <= rd_entry;
				gc_data[MARK_BIT] <= 1'b0;
			end else begin
				gc_data <= '0;
			end
		end
	end

endmodule

// ==== mac_table_top.sv ====
`timescale 1ns/1ps

module mac_table_top #(
	parameter int TABLE_ROWS   = 2048,
	parameter int ASSOC_WAYS   = 8,
	parameter int PENDING_SIZE = 8,
	parameter int NUM_PORTS    = 50,
	localparam int PORT_BITS   = $clog2(NUM_PORTS)
) (
	input  logic                 clk,
	input  logic                 reset,

	// Frame strobe
	input  logic                 lookup_en,
	input  eth_pkg::vlan_t       lookup_vlan,
	input  eth_pkg::mac_addr_t   lookup_src_mac,
	input  logic [PORT_BITS-1:0] lookup_src_port,
	input  eth_pkg::mac_addr_t   lookup_dst_mac,

	// Destination result, two cycles after the strobe
	output logic                 lookup_hit,
	output logic [PORT_BITS-1:0] lookup_dst_port,

	// Host GC control
	input  logic                 gc_en,
	output logic                 gc_done
);

	import eth_pkg::*;
	import mac_table_pkg::*;

	localparam int ROW_BITS = $clog2(TABLE_ROWS);
	localparam int WAY_BITS = $clog2(ASSOC_WAYS);
	localparam int ENTRY_W  = ENTRY_FIXED_BITS + PORT_BITS;

	// Row indexes, VLAN shared by source and destination
	logic [15:0]         src_hash;
	logic [15:0]         dst_hash;
	logic [ROW_BITS-1:0] src_index;
	logic [ROW_BITS-1:0] dst_index;

	assign src_hash  = mac_vlan_hash(lookup_src_mac, lookup_vlan);
	assign dst_hash  = mac_vlan_hash(lookup_dst_mac, lookup_vlan);
	assign src_index = src_hash[ROW_BITS-1:0];
	assign dst_index = dst_hash[ROW_BITS-1:0];

	// Per way read data
	logic [ASSOC_WAYS-1:0][ENTRY_W-1:0] a_rdata;
	logic [ASSOC_WAYS-1:0][ENTRY_W-1:0] b_rdata;

	// Maintenance port
	logic                  b_en;
	logic [ROW_BITS-1:0]   b_addr;
	logic [ASSOC_WAYS-1:0] b_we;
	logic [ENTRY_W-1:0]    b_wdata;

	// Learning path
	logic                 need_to_learn;
	mac_addr_t            learn_mac;
	vlan_t                learn_vlan;
	logic [PORT_BITS-1:0] learn_port;
	logic [WAY_BITS-1:0]  learn_way;
	logic                 learn_req;
	logic                 learn_grant;
	logic [ROW_BITS-1:0]  learn_row;
	logic [WAY_BITS-1:0]  learn_wr_way;
	logic [ENTRY_W-1:0]   learn_data;

	// GC path
	logic                gc_rd_req;
	logic                gc_wr_req;
	logic                gc_rd_grant;
	logic                gc_wr_grant;
	logic [ROW_BITS-1:0] gc_row;
	logic [WAY_BITS-1:0] gc_way;
	logic [ENTRY_W-1:0]  gc_data;

	//////////////////////////////
	// Table ways

	for (genvar g = 0; g < ASSOC_WAYS; g++) begin : g_way
		table_ram #(
			.WIDTH (ENTRY_W),
			.DEPTH (TABLE_ROWS)
		) i_table_ram (
			.clk     (clk),
			.a_en    (lookup_en),
			.a_addr  (dst_index),
			.a_rdata (a_rdata[g]),
			.b_en    (b_en),
			.b_we    (b_we[g]),
			.b_addr  (b_addr),
			.b_wdata (b_wdata),
			.b_rdata (b_rdata[g])
		);
	end

	//////////////////////////////
	// Port B control and datapath

	table_port_arbiter #(
		.TABLE_ROWS (TABLE_ROWS),
		.ASSOC_WAYS (ASSOC_WAYS),
		.NUM_PORTS  (NUM_PORTS)
	) i_table_port_arbiter (
		.clk         (clk),
		.reset       (reset),
		.lookup_en   (lookup_en),
		.src_index   (src_index),
		.learn_req   (learn_req),
		.learn_row   (learn_row),
		.learn_way   (learn_wr_way),
		.learn_data  (learn_data),
		.learn_grant (learn_grant),
		.gc_rd_req   (gc_rd_req),
		.gc_wr_req   (gc_wr_req),
		.gc_row      (gc_row),
		.gc_way      (gc_way),
		.gc_data     (gc_data),
		.gc_rd_grant (gc_rd_grant),
		.gc_wr_grant (gc_wr_grant),
		.b_en        (b_en),
		.b_addr      (b_addr),
		.b_we        (b_we),
		.b_wdata     (b_wdata)
	);

	dst_lookup #(
		.ASSOC_WAYS (ASSOC_WAYS),
		.NUM_PORTS  (NUM_PORTS)
	) i_dst_lookup (
		.clk             (clk),
		.reset           (reset),
		.lookup_en       (lookup_en),
		.lookup_vlan     (lookup_vlan),
		.lookup_dst_mac  (lookup_dst_mac),
		.a_rdata         (a_rdata),
		.lookup_hit      (lookup_hit),
		.lookup_dst_port (lookup_dst_port)
	);

	learn_check #(
		.ASSOC_WAYS (ASSOC_WAYS),
		.NUM_PORTS  (NUM_PORTS)
	) i_learn_check (
		.clk             (clk),
		.reset           (reset),
		.lookup_en       (lookup_en),
		.lookup_vlan     (lookup_vlan),
		.lookup_src_mac  (lookup_src_mac),
		.lookup_src_port (lookup_src_port),
		.b_rdata         (b_rdata),
		.need_to_learn   (need_to_learn),
		.learn_mac       (learn_mac),
		.learn_vlan      (learn_vlan),
		.learn_port      (learn_port),
		.learn_way       (learn_way)
	);

	learn_queue #(
		.TABLE_ROWS   (TABLE_ROWS),
		.ASSOC_WAYS   (ASSOC_WAYS),
		.PENDING_SIZE (PENDING_SIZE),
		.NUM_PORTS    (NUM_PORTS)
	) i_learn_queue (
		.clk           (clk),
		.reset         (reset),
		.need_to_learn (need_to_learn),
		.learn_mac     (learn_mac),
		.learn_vlan    (learn_vlan),
		.learn_port    (learn_port),
		.learn_way     (learn_way),
		.learn_grant   (learn_grant),
		.learn_req     (learn_req),
		.learn_row     (learn_row),
		.learn_way_out (learn_wr_way),
		.learn_data    (learn_data)
	);

	gc_sweeper #(
		.TABLE_ROWS (TABLE_ROWS),
		.ASSOC_WAYS (ASSOC_WAYS),
		.NUM_PORTS  (NUM_PORTS)
	) i_gc_sweeper (
		.clk         (clk),
		.reset       (reset),
		.gc_en       (gc_en),
		.gc_done     (gc_done),
		.b_rdata     (b_rdata),
		.gc_rd_grant (gc_rd_grant),
		.gc_wr_grant (gc_wr_grant),
		.gc_rd_req   (gc_rd_req),
		.gc_wr_req   (gc_wr_req),
		.gc_row      (gc_row),
		.gc_way      (gc_way),
		.gc_data     (gc_data)
	);

endmodule

// ==== tb_mac_table.sv ====
`timescale 1ns/1ps

module tb_mac_table;

	localparam int ROWS      = 16;
	localparam int WAYS      = 2;
	localparam int PENDING   = 8;
	localparam int PORTS     = 50;
	localparam int PORT_BITS = $clog2(PORTS);
	localparam int ROW_BITS  = $clog2(ROWS);
	localparam int NUM_LEARN = 10;
	localparam int NUM_MCAST = 4;

	// Fixed budget plus two full sweeps at about 8 cycles per entry
	localparam int MAX_CYCLES = 2000 + 2 * 8 * ROWS * WAYS;

	localparam logic [47:0] BCAST = 48'hffff_ffff_ffff;

	// Other VLAN differs only above the row bits so the same row is read
	localparam logic [11:0] VLAN_OFS = 12'(ROWS);

	logic                 clk = 1'b0;
	logic                 reset;
	logic                 lookup_en;
	logic [11:0]          lookup_vlan;
	logic [47:0]          lookup_src_mac;
	logic [PORT_BITS-1:0] lookup_src_port;
	logic [47:0]          lookup_dst_mac;
	logic                 lookup_hit;
	logic [PORT_BITS-1:0] lookup_dst_port;
	logic                 gc_en;
	logic                 gc_done;

	mac_table_top #(
		.TABLE_ROWS   (ROWS),
		.ASSOC_WAYS   (WAYS),
		.PENDING_SIZE (PENDING),
		.NUM_PORTS    (PORTS)
	) i_mac_table_top (
		.clk             (clk),
		.reset           (reset),
		.lookup_en       (lookup_en),
		.lookup_vlan     (lookup_vlan),
		.lookup_src_mac  (lookup_src_mac),
		.lookup_src_port (lookup_src_port),
		.lookup_dst_mac  (lookup_dst_mac),
		.lookup_hit      (lookup_hit),
		.lookup_dst_port (lookup_dst_port),
		.gc_en           (gc_en),
		.gc_done         (gc_done)
	);

	always #20 clk = ~clk;

	//////////////////////////////
	// Reference model

	// Learned unicast entries with the mark set at learning
	logic [47:0]          mdl_mac   [NUM_LEARN];
	logic [11:0]          mdl_vlan  [NUM_LEARN];
	logic [PORT_BITS-1:0] mdl_port  [NUM_LEARN];
	logic                 mdl_valid [NUM_LEARN];
	logic                 mdl_mark  [NUM_LEARN];
	int                   mdl_count = 0;

	// Rows already holding a learned address
	logic row_taken [ROWS];

	logic [47:0] mcast_mac  [NUM_MCAST];
	logic [11:0] mcast_vlan [NUM_MCAST];

	// Expected {hit, port} per strobe with the oldest first
	logic [PORT_BITS:0] exp_q [$];

	logic                 en_d1;
	logic                 chk_valid;
	logic                 chk_hit;
	logic [PORT_BITS-1:0] chk_port;

	logic gc_busy;
	int   gc_started = 0;
	int   done_count = 0;
	int   errors     = 0;
	int   checks     = 0;
	int   cycles     = 0;

	// Row index as the XOR fold of the three 16-bit address slices and the VLAN
	function automatic logic [ROW_BITS-1:0] row_of(input logic [47:0] mac,
		input logic [11:0] vlan);
		logic [15:0] h;
		h = mac[47:32] ^ mac[31:16] ^ mac[15:0] ^ {4'h0, vlan};
		return h[ROW_BITS-1:0];
	endfunction

	function automatic logic [PORT_BITS:0] expect_dst(input logic [47:0] mac,
		input logic [11:0] vlan);
		logic [PORT_BITS:0] res;
		res = '0;
		for (int i = 0; i < mdl_count; i++) begin
			if (mdl_valid[i] && (mdl_mac[i] == mac) && (mdl_vlan[i] == vlan)) begin
				res = {1'b1, mdl_port[i]};
			end
		end
		return res;
	endfunction

	// Group sources and known sources are not learned
	function automatic void model_learn(input logic [47:0] mac, input logic [11:0] vlan,
		input logic [PORT_BITS-1:0] port);
		if (mac[40]) begin
			return;
		end
		for (int i = 0; i < mdl_count; i++) begin
			if (mdl_valid[i] && (mdl_mac[i] == mac) && (mdl_vlan[i] == vlan)) begin
				return;
			end
		end
		mdl_mac[mdl_count]   = mac;
		mdl_vlan[mdl_count]  = vlan;
		mdl_port[mdl_count]  = port;
		mdl_valid[mdl_count] = 1'b1;
		mdl_mark[mdl_count]  = 1'b1;
		mdl_count++;
	endfunction

	// In one sweep marked entries lose the mark and unmarked ones go away
	function automatic void model_gc();
		for (int i = 0; i < mdl_count; i++) begin
			if (mdl_valid[i]) begin
				if (mdl_mark[i]) begin
					mdl_mark[i] = 1'b0;
				end else begin
					mdl_valid[i] = 1'b0;
				end
			end
		end
	endfunction

	//////////////////////////////
	// Result pipeline and checks

	// Result for the strobe seen at the previous edge is due next cycle
	always @(posedge clk) begin
		if (reset) begin
			en_d1     <= 1'b0;
			chk_valid <= 1'b0;
			chk_hit   <= 1'b0;
			chk_port  <= '0;
		end else begin
			en_d1 <= lookup_en;
			if (en_d1 && (exp_q.size() > 0)) begin
				chk_valid           <= 1'b1;
				{chk_hit, chk_port} <= exp_q.pop_front();
				checks++;
			end else begin
				chk_valid <= 1'b0;
				if (en_d1) begin
					errors++;
					$display("Strobe seen by the DUT with no expected result queued");
				end
			end
		end
	end

	always @(posedge clk) begin
		if (!reset && gc_done) begin
			done_count++;
		end
	end

	a_dst_result: assert property (@(posedge clk) disable iff (reset)
		chk_valid |-> (lookup_hit == chk_hit) && (!chk_hit || (lookup_dst_port == chk_port)))
	else begin
		errors++;
		$display("FAIL %0t: dst result hit=%0b port=%0d, expected hit=%0b port=%0d", $time,
			$sampled(lookup_hit), $sampled(lookup_dst_port), $sampled(chk_hit),
			$sampled(chk_port));
	end

	// No hit without a strobe two cycles earlier
	a_no_stray_hit: assert property (@(posedge clk) disable iff (reset)
		!chk_valid |-> !lookup_hit)
	else begin
		errors++;
		$display("FAIL %0t: lookup_hit high with no strobe pending", $time);
	end

	a_done_in_sweep: assert property (@(posedge clk) disable iff (reset)
		gc_done |-> gc_busy)
	else begin
		errors++;
		$display("FAIL %0t: gc_done pulse with no sweep outstanding", $time);
	end

	// Run limit
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped responding", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	//////////////////////////////
	// Stimulus tasks

	task automatic strobe(input logic [47:0] src, input logic [PORT_BITS-1:0] port,
		input logic [47:0] dst, input logic [11:0] vlan);
		@(posedge clk);
		#2;
		lookup_en       = 1'b1;
		lookup_src_mac  = src;
		lookup_src_port = port;
		lookup_dst_mac  = dst;
		lookup_vlan     = vlan;
		gc_en           = 1'b0;
		exp_q.push_back(expect_dst(dst, vlan));
		model_learn(src, vlan, port);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
			lookup_en = 1'b0;
			gc_en     = 1'b0;
		end
	endtask

	// Random unicast address whose row holds nothing yet
	task automatic pick_new(output logic [47:0] mac, output logic [11:0] vlan);
		logic [ROW_BITS-1:0] row;
		do begin
			mac     = {16'($urandom), $urandom};
			mac[40] = 1'b0;
			vlan    = 12'($urandom_range(4, 1));
			row     = row_of(mac, vlan);
		end while (row_taken[row]);
		row_taken[row] = 1'b1;
	endtask

	// A broadcast source keeps checking from learning anything
	task automatic check_learned(input bit other_vlan);
		for (int i = 0; i < mdl_count; i++) begin
			if (other_vlan) begin
				strobe(BCAST, '0, mdl_mac[i], mdl_vlan[i] + VLAN_OFS);
			end else begin
				strobe(BCAST, '0, mdl_mac[i], mdl_vlan[i]);
			end
		end
		idle(4);
	endtask

	task automatic run_gc;
		@(posedge clk);
		#2;
		lookup_en = 1'b0;
		gc_en     = 1'b1;
		gc_busy   = 1'b1;
		gc_started++;
		idle(10);
		// Extra request mid sweep while the collector is busy
		gc_en = 1'b1;
		idle(1);
		while (!gc_done) begin
			@(posedge clk);
			#2;
		end
		// Pulse is one cycle wide
		idle(1);
		gc_busy = 1'b0;
		assert (done_count == gc_started) else begin
			errors++;
			$display("FAIL %0t: %0d gc_done pulses for %0d sweeps", $time, done_count,
				gc_started);
		end
		model_gc();
	endtask

	//////////////////////////////
	// Test sequence

	initial begin
		logic [47:0]          mac;
		logic [11:0]          vlan;
		logic [PORT_BITS-1:0] port;
		int                   k;

		void'($urandom(32'hcc85));
		reset           = 1'b1;
		lookup_en       = 1'b0;
		lookup_vlan     = '0;
		lookup_src_mac  = '0;
		lookup_src_port = '0;
		lookup_dst_mac  = '0;
		gc_en           = 1'b0;
		gc_busy         = 1'b0;
		for (int i = 0; i < ROWS; i++) begin
			row_taken[i] = 1'b0;
		end
		repeat (8) @(posedge clk);
		#2;
		reset = 1'b0;

		// Everything misses in the empty table
		idle(10);
		for (int i = 0; i < 4; i++) begin
			strobe(BCAST, '0, {16'($urandom), $urandom}, 12'($urandom_range(4, 1)));
		end
		idle(40);

		// Learning with the last source sent twice in a row
		for (int i = 0; i < NUM_LEARN; i++) begin
			pick_new(mac, vlan);
			port = PORT_BITS'($urandom_range(PORTS - 1, 0));
			strobe(mac, port, BCAST, vlan);
			if (i == NUM_LEARN - 1) begin
				strobe(mac, port, BCAST, vlan);
			end
			idle(6);
		end
		idle(40);
		check_learned(1'b0);
		check_learned(1'b1);

		// Group sources
		for (int i = 0; i < NUM_MCAST; i++) begin
			mcast_mac[i]     = {16'($urandom), $urandom};
			mcast_mac[i][40] = 1'b1;
			mcast_vlan[i]    = 12'($urandom_range(4, 1));
			strobe(mcast_mac[i], PORT_BITS'($urandom_range(PORTS - 1, 0)), BCAST,
				mcast_vlan[i]);
			idle(6);
		end
		idle(40);
		for (int i = 0; i < NUM_MCAST; i++) begin
			strobe(BCAST, '0, mcast_mac[i], mcast_vlan[i]);
		end
		idle(4);

		// Back to back strobes mixing hits and misses
		for (int i = 0; i < 24; i++) begin
			k = $urandom_range(mdl_count - 1, 0);
			case ($urandom_range(2, 0))
				0: strobe(BCAST, '0, mdl_mac[k], mdl_vlan[k]);
				1: strobe(BCAST, '0, mdl_mac[k], mdl_vlan[k] + VLAN_OFS);
				default: strobe(BCAST, '0, {16'($urandom), $urandom},
					12'($urandom_range(4, 1)));
			endcase
		end
		idle(40);

		// The first sweep keeps everything and the second one clears it
		run_gc();
		idle(4);
		check_learned(1'b0);
		run_gc();
		idle(4);
		check_learned(1'b0);
		idle(4);

		if (exp_q.size() != 0) begin
			errors++;
			$display("%0d expected results were never checked", exp_q.size());
		end
		$display("Summary: %0d errors, %0d lookups checked, %0d sweeps", errors, checks,
			done_count);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// ==== tb.f ====
eth_pkg.sv
mac_table_pkg.sv
table_ram.sv
table_port_arbiter.sv
dst_lookup.sv
learn_check.sv
learn_queue.sv
gc_sweeper.sv
mac_table_top.sv
tb_mac_table.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_mac_table -f tb.f
out=$(./obj_dir/Vtb_mac_table)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
